/* Makefile */
SIM  := obj_dir/Vtb_l2_subsystem
SRCS := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f \
		--top-module tb_l2_subsystem -Mdir obj_dir -o Vtb_l2_subsystem

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+source
source/l2_pkg.sv
source/l2_sram_bank.sv
source/l2_axil_frontend.sv
source/l2_bank_router.sv
source/l2_ram_multi_bank.sv
source/l2_axil_resp.sv
source/l2_subsystem_top.sv
verif/tb_l2_subsystem.sv

/* source/l2_axil_frontend.sv */
// AXI4-Lite request side
// One transaction in flight; nothing is accepted while rsp_busy_i is high
// A write is taken only when AW and W are valid together
// Reads and writes alternate when both are pending

`timescale 1ns/1ps

`include "l2_params.svh"

module l2_axil_frontend (
   input  logic               clk_i,
   input  logic               rst_ni,
   input  l2_pkg::l2_addr_t   awaddr_i,
   input  logic               awvalid_i,
   output logic               awready_o,
   input  l2_pkg::l2_data_t   wdata_i,
   input  l2_pkg::l2_strb_t   wstrb_i,
   input  logic               wvalid_i,
   output logic               wready_o,
   input  l2_pkg::l2_addr_t   araddr_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   input  logic               rsp_busy_i,
   output l2_pkg::l2_req_t    req_o,
   output logic               req_valid_o
);
   import l2_pkg::*;

   fe_state_e state_q, state_d;
   l2_req_t   req_q;
   logic      last_wr_q;  // Last grant went to the write side
   logic      wr_pend, rd_pend;
   logic      grant_wr, grant_rd;
   logic      can_accept, accept;

   assign wr_pend = awvalid_i && wvalid_i;
   assign rd_pend = arvalid_i;

   // Alternating priority when both sides wait
   assign grant_wr = wr_pend && (!rd_pend || !last_wr_q);
   assign grant_rd = rd_pend && !grant_wr;

   // WAIT_RSP can take the next request as soon as the response is gone
   assign can_accept = !rsp_busy_i && (state_q == IDLE || state_q == WAIT_RSP);
   assign accept     = can_accept && (grant_wr || grant_rd);

   assign awready_o   = can_accept && grant_wr;
   assign wready_o    = can_accept && grant_wr;
   assign arready_o   = can_accept && grant_rd;
   assign req_valid_o = (state_q == ISSUE);
   assign req_o       = req_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (accept) state_d = ISSUE;
         end
         ISSUE: state_d = WAIT_RSP;  // Single-cycle request pulse
         WAIT_RSP: begin
            if (accept) begin
               state_d = ISSUE;
            end else if (!rsp_busy_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q   <= IDLE;
         last_wr_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) last_wr_q <= grant_wr;
      end
   end

   // Request payload
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q.addr  <= grant_wr ? awaddr_i : araddr_i;
         req_q.wdata <= wdata_i;
         req_q.be    <= grant_wr ? wstrb_i : '1;  // Reads fetch the full word
         req_q.wen   <= grant_wr;
      end
   end

   // Response stage has to block new requests once one is out
   a_busy_after_req : assert property (
      @(posedge clk_i) disable iff (!rst_ni) req_valid_o |=> rsp_busy_i
   ) else $error("rsp_busy_i low in the cycle after req_valid_o");

endmodule

/* source/l2_axil_resp.sv */
// B and R response stage
// Holds a single beat until the master takes it
// Busy covers the issue cycle up to the response handshake

`timescale 1ns/1ps

module l2_axil_resp (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  logic              req_valid_i,
   input  l2_pkg::l2_rsp_t   rsp_i,
   output logic              bvalid_o,
   output l2_pkg::axi_resp_t bresp_o,
   input  logic              bready_i,
   output logic              rvalid_o,
   output l2_pkg::l2_data_t  rdata_o,
   output l2_pkg::axi_resp_t rresp_o,
   input  logic              rready_i,
   output logic              rsp_busy_o
);
   import l2_pkg::*;

   logic      busy_q, bvalid_q, rvalid_q;
   axi_resp_t bresp_q, rresp_q;
   l2_data_t  rdata_q;
   logic      done;

   assign done = (bvalid_q && bready_i) || (rvalid_q && rready_i);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         busy_q   <= 1'b0;
         bvalid_q <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         if (req_valid_i)  busy_q <= 1'b1;
         else if (done)    busy_q <= 1'b0;

         if (rsp_i.valid && !rsp_i.is_read) bvalid_q <= 1'b1;
         else if (bready_i)                 bvalid_q <= 1'b0;

         if (rsp_i.valid && rsp_i.is_read)  rvalid_q <= 1'b1;
         else if (rready_i)                 rvalid_q <= 1'b0;
      end
   end

   // Beat payload, captured once per transaction
   always_ff @(posedge clk_i) begin
      if (rsp_i.valid) begin
         if (rsp_i.is_read) begin
            rdata_q <= rsp_i.rdata;
            rresp_q <= rsp_i.resp;
         end else begin
            bresp_q <= rsp_i.resp;
         end
      end
   end

   assign bvalid_o   = bvalid_q;
   assign bresp_o    = bresp_q;
   assign rvalid_o   = rvalid_q;
   assign rdata_o    = rdata_q;
   assign rresp_o    = rresp_q;
   assign rsp_busy_o = busy_q || req_valid_i;

   a_one_beat : assert property (
      @(posedge clk_i) disable iff (!rst_ni) !(bvalid_o && rvalid_o)
   ) else $error("bvalid_o and rvalid_o high together");

endmodule

/* source/l2_bank_router.sv */
// Region decode and bank selection
// Interleaved region: word bits just above the byte offset pick the bank
// Private regions are each mapped onto one whole bank
// Addresses outside all regions give zero data and SLVERR, no bank access

`timescale 1ns/1ps

`include "l2_params.svh"

module l2_bank_router (
   input  logic                                      clk_i,
   input  logic                                      rst_ni,
   input  l2_pkg::l2_req_t                           req_i,
   input  logic                                      req_valid_i,
   output l2_pkg::l2_bank_req_t [`L2_NB_PORTS-1:0]   bank_req_o,
   input  l2_pkg::l2_data_t [`L2_NB_PORTS-1:0]       bank_rdata_i,
   input  logic [`L2_NB_PORTS-1:0]                   bank_rvalid_i,
   output l2_pkg::l2_rsp_t                           rsp_o
);
   import l2_pkg::*;

   localparam int unsigned SEL_W      = $clog2(`L2_NB_PORTS);
   localparam int unsigned BSEL_W     = $clog2(`L2_NB_BANKS);
   localparam int unsigned INTL_ROW_W = $clog2(`L2_INTL_BANK_WORDS);
   localparam int unsigned PRI_ROW_W  = $clog2(`L2_PRI_BANK_WORDS);

   l2_addr_t                intl_off, pri0_off, pri1_off;
   logic                    hit_intl, hit_pri0, hit_pri1, hit;
   logic [SEL_W-1:0]        sel, sel_q;
   l2_row_t                 row;
   logic [`L2_NB_PORTS-1:0] req_vec;
   logic                    vld_q, err_q, rd_q;

   // Offsets wrap below the base, so one unsigned compare covers both ends
   assign intl_off = req_i.addr - l2_addr_t'(`L2_INTL_START_ADDR);
   assign pri0_off = req_i.addr - l2_addr_t'(`L2_PRI0_START_ADDR);
   assign pri1_off = req_i.addr - l2_addr_t'(`L2_PRI1_START_ADDR);

   assign hit_intl = intl_off < l2_addr_t'(`L2_INTL_SIZE);
   assign hit_pri0 = pri0_off < l2_addr_t'(`L2_PRI_SIZE);
   assign hit_pri1 = pri1_off < l2_addr_t'(`L2_PRI_SIZE);
   assign hit      = hit_intl || hit_pri0 || hit_pri1;

   always_comb begin
      sel = '0;
      row = '0;
      if (hit_intl) begin
         sel = SEL_W'(intl_off[2 +: BSEL_W]);
         row = l2_row_t'(intl_off[2+BSEL_W +: INTL_ROW_W]);
      end else if (hit_pri0) begin
         sel = SEL_W'(`L2_NB_BANKS);
         row = l2_row_t'(pri0_off[2 +: PRI_ROW_W]);
      end else if (hit_pri1) begin
         sel = SEL_W'(`L2_NB_BANKS + 1);
         row = l2_row_t'(pri1_off[2 +: PRI_ROW_W]);
      end
   end

   for (genvar i = 0; i < `L2_NB_PORTS; i++) begin : g_port
      assign req_vec[i]    = req_valid_i && hit && (sel == SEL_W'(i));
      assign bank_req_o[i] = '{req:   req_vec[i],
                               wen:   req_i.wen,
                               be:    req_i.be,
                               row:   row,
                               wdata: req_i.wdata};
   end

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) vld_q <= 1'b0;
      else         vld_q <= req_valid_i;
   end

   // Kept for the cycle in which the bank answers
   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         sel_q <= sel;
         err_q <= !hit;
         rd_q  <= !req_i.wen;
      end
   end

   always_comb begin
      rsp_o.valid   = vld_q && (err_q || bank_rvalid_i[sel_q]);
      rsp_o.is_read = rd_q;
      rsp_o.rdata   = err_q ? '0 : bank_rdata_i[sel_q];
      rsp_o.resp    = err_q ? `L2_RESP_SLVERR : `L2_RESP_OKAY;
   end

   // Selected bank answers with the fixed one-cycle latency
   a_bank_answers : assert property (
      @(posedge clk_i) disable iff (!rst_ni) vld_q && !err_q |-> bank_rvalid_i[sel_q]
   ) else $error("Selected bank did not answer one cycle after the request");

endmodule

/* source/l2_params.svh */
// Build-time configuration of the L2 memory subsystem
// L2_NB_BANKS must stay a power of two and at least 2
// Region bases must not overlap the sizes derived below
// Bank depths must be powers of two

`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

`define L2_NB_BANKS        4
`define L2_NB_PORTS        (`L2_NB_BANKS + 2)  // Interleaved banks plus two private ones

`define L2_INTL_BANK_WORDS 256
`define L2_PRI_BANK_WORDS  256
`define L2_MAX_BANK_WORDS  ((`L2_INTL_BANK_WORDS > `L2_PRI_BANK_WORDS) ? \
                            `L2_INTL_BANK_WORDS : `L2_PRI_BANK_WORDS)

`define L2_INTL_START_ADDR 32'h1C00_0000
`define L2_PRI0_START_ADDR 32'h1C01_0000
`define L2_PRI1_START_ADDR 32'h1C01_1000

// Region sizes in bytes
`define L2_INTL_SIZE       (`L2_NB_BANKS * `L2_INTL_BANK_WORDS * 4)
`define L2_PRI_SIZE        (`L2_PRI_BANK_WORDS * 4)

`define L2_ADDR_W          32
`define L2_DATA_W          32

`define L2_RESP_OKAY       2'b00
`define L2_RESP_SLVERR     2'b10

`endif

/* source/l2_pkg.sv */
// Shared types of the L2 memory subsystem
// Widths come from the macros of the params header

`include "l2_params.svh"

package l2_pkg;

   typedef logic [`L2_ADDR_W-1:0]                 l2_addr_t;  // Byte address
   typedef logic [`L2_DATA_W-1:0]                 l2_data_t;
   typedef logic [`L2_DATA_W/8-1:0]               l2_strb_t;
   typedef logic [$clog2(`L2_MAX_BANK_WORDS)-1:0] l2_row_t;   // Word index inside a bank
   typedef logic [1:0]                            axi_resp_t;

   // Request issued by the front end
   typedef struct packed {
      l2_addr_t addr;
      l2_data_t wdata;
      l2_strb_t be;
      logic     wen;  // High for write
   } l2_req_t;

   // One bank port, driven by the router
   typedef struct packed {
      logic     req;
      logic     wen;
      l2_strb_t be;
      l2_row_t  row;
      l2_data_t wdata;
   } l2_bank_req_t;

   // Completed access towards the response stage
   typedef struct packed {
      logic      valid;
      logic      is_read;
      l2_data_t  rdata;
      axi_resp_t resp;
   } l2_rsp_t;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      WAIT_RSP
   } fe_state_e;

endpackage

/* source/l2_ram_multi_bank.sv */
// Interleaved banks followed by the two private banks
// Every request is granted at once; read data follows one cycle later
// Ports 0 to L2_NB_BANKS-1 are interleaved, the last two are private

`timescale 1ns/1ps

`include "l2_params.svh"

module l2_ram_multi_bank (
   input  logic                                      clk_i,
   input  logic                                      rst_ni,
   input  l2_pkg::l2_bank_req_t [`L2_NB_PORTS-1:0]   bank_req_i,
   output l2_pkg::l2_data_t [`L2_NB_PORTS-1:0]       bank_rdata_o,
   output logic [`L2_NB_PORTS-1:0]                   bank_rvalid_o
);

   logic [`L2_NB_PORTS-1:0] bank_gnt;

   // Fixed one-cycle latency
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         bank_rvalid_o <= '0;
      end else begin
         bank_rvalid_o <= bank_gnt;
      end
   end

   for (genvar i = 0; i < `L2_NB_PORTS; i++) begin : g_bank
      localparam int unsigned WORDS = (i < `L2_NB_BANKS) ? `L2_INTL_BANK_WORDS
                                                         : `L2_PRI_BANK_WORDS;

      assign bank_gnt[i] = bank_req_i[i].req;  // No back-pressure

      l2_sram_bank #(
         .WORDS   ( WORDS               )
      ) u_bank (
         .clk_i   ( clk_i               ),
         .req_i   ( bank_gnt[i]         ),
         .wen_i   ( bank_req_i[i].wen   ),
         .be_i    ( bank_req_i[i].be    ),
         .row_i   ( bank_req_i[i].row   ),
         .wdata_i ( bank_req_i[i].wdata ),
         .rdata_o ( bank_rdata_o[i]     )
      );
   end

   // The router serves one bank per cycle
   a_one_gnt : assert property (
      @(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_gnt)
   ) else $error("More than one bank granted in the same cycle");

endmodule

/* source/l2_sram_bank.sv */
// Single-port word memory with byte-enable writes
// Read data is registered and holds until the next read
// WORDS must be a power of two; upper row bits beyond it are ignored

`timescale 1ns/1ps

module l2_sram_bank #(
   parameter int unsigned WORDS = 256
) (
   input  logic             clk_i,
   input  logic             req_i,
   input  logic             wen_i,
   input  l2_pkg::l2_strb_t be_i,
   input  l2_pkg::l2_row_t  row_i,
   input  l2_pkg::l2_data_t wdata_i,
   output l2_pkg::l2_data_t rdata_o
);
   import l2_pkg::*;

   localparam int unsigned ROW_W = $clog2(WORDS);

   l2_data_t         mem_q [WORDS];
   logic [ROW_W-1:0] idx;

   assign idx = row_i[ROW_W-1:0];

   always_ff @(posedge clk_i) begin
      if (req_i) begin
         if (wen_i) begin
            for (int b = 0; b < $bits(l2_strb_t); b++) begin
               if (be_i[b]) mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end else begin
            rdata_o <= mem_q[idx];  // Write leaves the old read word in place
         end
      end
   end

endmodule

/* source/l2_subsystem_top.sv */
// L2 memory subsystem with an AXI4-Lite slave port
// No IDs, bursts or protection bits; one transaction in flight

`timescale 1ns/1ps

`include "l2_params.svh"

module l2_subsystem_top (
   input  logic              clk_i,
   input  logic              rst_ni,
   input  l2_pkg::l2_addr_t  awaddr_i,
   input  logic              awvalid_i,
   output logic              awready_o,
   input  l2_pkg::l2_data_t  wdata_i,
   input  l2_pkg::l2_strb_t  wstrb_i,
   input  logic              wvalid_i,
   output logic              wready_o,
   output l2_pkg::axi_resp_t bresp_o,
   output logic              bvalid_o,
   input  logic              bready_i,
   input  l2_pkg::l2_addr_t  araddr_i,
   input  logic              arvalid_i,
   output logic              arready_o,
   output l2_pkg::l2_data_t  rdata_o,
   output l2_pkg::axi_resp_t rresp_o,
   output logic              rvalid_o,
   input  logic              rready_i
);
   import l2_pkg::*;

   l2_req_t                           req;
   logic                              req_valid;
   logic                              rsp_busy;
   l2_bank_req_t [`L2_NB_PORTS-1:0]   bank_req;
   l2_data_t [`L2_NB_PORTS-1:0]       bank_rdata;
   logic [`L2_NB_PORTS-1:0]           bank_rvalid;
   l2_rsp_t                           rsp;

   l2_axil_frontend u_frontend (
      .clk_i       ( clk_i     ),
      .rst_ni      ( rst_ni    ),
      .awaddr_i    ( awaddr_i  ),
      .awvalid_i   ( awvalid_i ),
      .awready_o   ( awready_o ),
      .wdata_i     ( wdata_i   ),
      .wstrb_i     ( wstrb_i   ),
      .wvalid_i    ( wvalid_i  ),
      .wready_o    ( wready_o  ),
      .araddr_i    ( araddr_i  ),
      .arvalid_i   ( arvalid_i ),
      .arready_o   ( arready_o ),
      .rsp_busy_i  ( rsp_busy  ),
      .req_o       ( req       ),
      .req_valid_o ( req_valid )
   );

   l2_bank_router u_router (
      .clk_i         ( clk_i       ),
      .rst_ni        ( rst_ni      ),
      .req_i         ( req         ),
      .req_valid_i   ( req_valid   ),
      .bank_req_o    ( bank_req    ),
      .bank_rdata_i  ( bank_rdata  ),
      .bank_rvalid_i ( bank_rvalid ),
      .rsp_o         ( rsp         )
   );

   l2_ram_multi_bank u_ram (
      .clk_i         ( clk_i       ),
      .rst_ni        ( rst_ni      ),
      .bank_req_i    ( bank_req    ),
      .bank_rdata_o  ( bank_rdata  ),
      .bank_rvalid_o ( bank_rvalid )
   );

   l2_axil_resp u_resp (
      .clk_i       ( clk_i     ),
      .rst_ni      ( rst_ni    ),
      .req_valid_i ( req_valid ),
      .rsp_i       ( rsp       ),
      .bvalid_o    ( bvalid_o  ),
      .bresp_o     ( bresp_o   ),
      .bready_i    ( bready_i  ),
      .rvalid_o    ( rvalid_o  ),
      .rdata_o     ( rdata_o   ),
      .rresp_o     ( rresp_o   ),
      .rready_i    ( rready_i  ),
      .rsp_busy_o  ( rsp_busy  )
   );

endmodule

/* verif/tb_l2_subsystem.sv */
// Table-driven testbench for the L2 memory subsystem
// Expected values come from a byte-wise reference memory filled before the run
// Only word-aligned addresses are used; reads target words written earlier
// Inputs change on falling edges, outputs are sampled between edges

`timescale 1ns/1ps

`include "l2_params.svh"

module tb_l2_subsystem;
   import l2_pkg::*;

   localparam int unsigned CLK_PERIOD = 20;
   localparam int unsigned RST_CYCLES = 5;
   localparam int unsigned MAX_STALL  = 3;
   localparam l2_addr_t    INTL       = `L2_INTL_START_ADDR;
   localparam l2_addr_t    PRI0       = `L2_PRI0_START_ADDR;
   localparam l2_addr_t    PRI1       = `L2_PRI1_START_ADDR;

   typedef struct packed {
      logic      wr;
      l2_addr_t  addr;
      l2_data_t  wdata;
      l2_strb_t  strb;
      l2_data_t  exp_rdata;
      axi_resp_t exp_resp;
   } entry_t;

   logic      clk_i, rst_ni;
   l2_addr_t  awaddr_i, araddr_i;
   logic      awvalid_i, wvalid_i, arvalid_i, bready_i, rready_i;
   logic      awready_o, wready_o, arready_o, bvalid_o, rvalid_o;
   l2_data_t  wdata_i, rdata_o;
   l2_strb_t  wstrb_i;
   axi_resp_t bresp_o, rresp_o;

   entry_t      table_q[$];
   logic [7:0]  ref_mem [l2_addr_t];  // Reference bytes, keyed by byte address
   integer      seed        = 65;
   int unsigned error_count = 0;
   int unsigned b_count     = 0;
   int unsigned r_count     = 0;
   bit          table_ready = 1'b0;

   l2_subsystem_top u_dut (
      .clk_i     ( clk_i     ),
      .rst_ni    ( rst_ni    ),
      .awaddr_i  ( awaddr_i  ),
      .awvalid_i ( awvalid_i ),
      .awready_o ( awready_o ),
      .wdata_i   ( wdata_i   ),
      .wstrb_i   ( wstrb_i   ),
      .wvalid_i  ( wvalid_i  ),
      .wready_o  ( wready_o  ),
      .bresp_o   ( bresp_o   ),
      .bvalid_o  ( bvalid_o  ),
      .bready_i  ( bready_i  ),
      .araddr_i  ( araddr_i  ),
      .arvalid_i ( arvalid_i ),
      .arready_o ( arready_o ),
      .rdata_o   ( rdata_o   ),
      .rresp_o   ( rresp_o   ),
      .rvalid_o  ( rvalid_o  ),
      .rready_i  ( rready_i  )
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   // Handshakes counted mid-cycle, before the rising edge that completes them
   always @(negedge clk_i) begin
      #1;
      if (rst_ni && bvalid_o && bready_i) b_count++;
      if (rst_ni && rvalid_o && rready_i) r_count++;
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("Fail at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
      error_count++;
   endtask

   task automatic note_failure(input string what);
      $display("Error at %0t: %s", $time, what);
      error_count++;
   endtask

   function automatic bit is_mapped(input l2_addr_t a);
      return (a >= INTL && a < INTL + `L2_INTL_SIZE) ||
             (a >= PRI0 && a < PRI0 + `L2_PRI_SIZE)  ||
             (a >= PRI1 && a < PRI1 + `L2_PRI_SIZE);
   endfunction

   function automatic l2_data_t ref_word(input l2_addr_t a);
      l2_data_t w;
      for (int b = 0; b < 4; b++) begin
         w[8*b +: 8] = ref_mem.exists(a + b) ? ref_mem[a + b] : 8'hxx;
      end
      return w;
   endfunction

   function automatic logic beat_valid(input bit wr);
      return wr ? bvalid_o : rvalid_o;
   endfunction

   function automatic axi_resp_t beat_resp(input bit wr);
      return wr ? bresp_o : rresp_o;
   endfunction

   task automatic add_entry(input bit wr, input l2_addr_t a, input l2_data_t d,
                            input l2_strb_t s);
      table_q.push_back('{wr: wr, addr: a, wdata: d, strb: s, exp_rdata: '0, exp_resp: '0});
   endtask

   task automatic build_table();
      l2_addr_t a;
      l2_data_t d;
      add_entry(1'b1, INTL, 32'hA5A5_0001, 4'hF);  // Write then read back
      add_entry(1'b0, INTL, '0, 4'h0);
      for (int k = 0; k < `L2_NB_BANKS; k++) begin  // Row 1 of every bank
         add_entry(1'b1, INTL + 32'h10 + 4*k, 32'hB000_0010 + k, 4'hF);
      end
      for (int k = 0; k < `L2_NB_BANKS; k++) add_entry(1'b0, INTL + 32'h10 + 4*k, '0, 4'h0);
      add_entry(1'b1, INTL + 32'hFFC, 32'hC0DE_0FFC, 4'hF);  // Last interleaved word
      add_entry(1'b0, INTL + 32'hFFC, '0, 4'h0);
      add_entry(1'b0, INTL + 32'h10, '0, 4'h0);
      // Equal offsets in all three regions
      add_entry(1'b1, PRI0 + 32'h20, 32'h0000_AAA0, 4'hF);
      add_entry(1'b1, PRI1 + 32'h20, 32'h1111_BBB1, 4'hF);
      add_entry(1'b1, INTL + 32'h20, 32'h2222_CCC2, 4'hF);
      add_entry(1'b0, PRI0 + 32'h20, '0, 4'h0);
      add_entry(1'b0, PRI1 + 32'h20, '0, 4'h0);
      add_entry(1'b0, INTL + 32'h20, '0, 4'h0);
      add_entry(1'b1, PRI0 + 32'h3FC, 32'hDEAD_03FC, 4'hF);
      add_entry(1'b0, PRI0 + 32'h3FC, '0, 4'h0);
      // Partial strobes
      add_entry(1'b1, INTL + 32'h40, 32'h1122_3344, 4'hF);
      add_entry(1'b1, INTL + 32'h40, 32'hAABB_CCDD, 4'b0101);
      add_entry(1'b0, INTL + 32'h40, '0, 4'h0);
      add_entry(1'b1, PRI1 + 32'h20, 32'h5A00_0000, 4'b1000);
      add_entry(1'b0, PRI1 + 32'h20, '0, 4'h0);
      // Unmapped addresses around the regions
      // Their low row bits match the mapped word read right after
      add_entry(1'b1, INTL + `L2_INTL_SIZE, 32'hFFFF_FFFF, 4'hF);
      add_entry(1'b0, INTL + `L2_INTL_SIZE, '0, 4'h0);
      add_entry(1'b0, INTL, '0, 4'h0);
      add_entry(1'b1, PRI0 + `L2_PRI_SIZE + 32'h3FC, 32'hEEEE_EEEE, 4'hF);
      add_entry(1'b0, PRI0 + 32'h3FC, '0, 4'h0);
      add_entry(1'b0, 32'h0000_0000, '0, 4'h0);
      add_entry(1'b1, PRI1 + `L2_PRI_SIZE + 32'h20, 32'hDDDD_DDDD, 4'hF);
      add_entry(1'b0, PRI1 + 32'h20, '0, 4'h0);
      for (int n = 0; n < 8; n++) begin  // Random words of the interleaved region
         a = INTL + ((l2_addr_t'($random(seed)) % 1024) << 2);
         d = l2_data_t'($random(seed));
         add_entry(1'b1, a, d, 4'hF);
         add_entry(1'b0, a, '0, 4'h0);
      end
   endtask

   task automatic fill_expected();
      entry_t   e;
      l2_addr_t a;
      for (int i = 0; i < table_q.size(); i++) begin
         e = table_q[i];
         a = {e.addr[31:2], 2'b00};
         if (!is_mapped(a)) begin
            e.exp_resp  = `L2_RESP_SLVERR;
            e.exp_rdata = '0;
         end else begin
            e.exp_resp = `L2_RESP_OKAY;
            if (e.wr) begin
               for (int b = 0; b < 4; b++) begin
                  if (e.strb[b]) ref_mem[a + b] = e.wdata[8*b +: 8];
               end
            end
            e.exp_rdata = ref_word(a);
         end
         table_q[i] = e;
      end
   endtask

   task automatic check_idle();
      assert (!awready_o) else report_mismatch("awready_o", 0, awready_o);
      assert (!wready_o)  else report_mismatch("wready_o", 0, wready_o);
      assert (!arready_o) else report_mismatch("arready_o", 0, arready_o);
      assert (!bvalid_o)  else report_mismatch("bvalid_o", 0, bvalid_o);
      assert (!rvalid_o)  else report_mismatch("rvalid_o", 0, rvalid_o);
   endtask

   task automatic run_entry(input entry_t e);
      int unsigned stall;
      int unsigned lat;
      bit          seen;
      string       rname;
      axi_resp_t   hold_resp;
      l2_data_t    hold_data;
      rname = e.wr ? "bresp_o" : "rresp_o";
      @(negedge clk_i);
      if (e.wr) begin
         awaddr_i  = e.addr;
         wdata_i   = e.wdata;
         wstrb_i   = e.strb;
         awvalid_i = 1'b1;
         wvalid_i  = 1'b1;
      end else begin
         araddr_i  = e.addr;
         arvalid_i = 1'b1;
      end
      seen = 1'b0;
      while (!seen) begin
         #1;  // Let the combinational ready settle
         seen = e.wr ? awready_o : arready_o;
         if (e.wr) begin
            assert (wready_o == awready_o)
               else report_mismatch("wready_o", awready_o, wready_o);
         end
         @(negedge clk_i);
      end
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
      arvalid_i = 1'b0;
      stall = $unsigned($random(seed)) % (MAX_STALL + 1);
      lat   = 0;
      do begin
         @(negedge clk_i);
         lat++;
      end while (!beat_valid(e.wr));
      assert (lat == 2) else report_mismatch("response latency", 2, lat);
      hold_resp = beat_resp(e.wr);
      hold_data = rdata_o;
      repeat (stall) begin  // Beat must hold while ready is low
         @(negedge clk_i);
         assert (beat_valid(e.wr)) else note_failure("response valid dropped before ready");
         assert (beat_resp(e.wr) == hold_resp)
            else report_mismatch(rname, hold_resp, beat_resp(e.wr));
         if (!e.wr) begin
            assert (rdata_o === hold_data)
               else report_mismatch("rdata_o", hold_data, rdata_o);
         end
      end
      assert (beat_resp(e.wr) == e.exp_resp)
         else report_mismatch(rname, e.exp_resp, beat_resp(e.wr));
      if (!e.wr) begin
         assert (rdata_o === e.exp_rdata)
            else report_mismatch("rdata_o", e.exp_rdata, rdata_o);
      end
      bready_i = e.wr;
      rready_i = !e.wr;
      @(negedge clk_i);
      bready_i = 1'b0;
      rready_i = 1'b0;
      assert (!bvalid_o && !rvalid_o) else note_failure("response still valid after handshake");
   endtask

   initial begin : watchdog
      wait (table_ready);
      repeat (table_q.size() * 40) @(posedge clk_i);
      $display("Timeout: the run did not finish within %0d cycles", table_q.size() * 40);
      $display("Simulation failed");
      $finish;
   end

   initial begin : main
      int unsigned exp_b;
      int unsigned exp_r;
      int unsigned errors_before;
      string       kind;
      rst_ni    = 1'b0;
      awaddr_i  = '0;
      awvalid_i = 1'b0;
      wdata_i   = '0;
      wstrb_i   = '0;
      wvalid_i  = 1'b0;
      bready_i  = 1'b0;
      araddr_i  = '0;
      arvalid_i = 1'b0;
      rready_i  = 1'b0;
      exp_b     = 0;
      exp_r     = 0;
      build_table();
      fill_expected();
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(negedge clk_i);
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_idle();
      for (int i = 0; i < table_q.size(); i++) begin
         errors_before = error_count;
         run_entry(table_q[i]);
         if (table_q[i].wr) exp_b++;
         else               exp_r++;
         assert (b_count == exp_b) else report_mismatch("B beat count", exp_b, b_count);
         assert (r_count == exp_r) else report_mismatch("R beat count", exp_r, r_count);
         kind = table_q[i].wr ? "write" : "read";
         $display("Entry %0d %s 0x%08h: %s", i, kind, table_q[i].addr,
                  (error_count == errors_before) ? "ok" : "mismatch");
      end
      $display("Entries %0d, B beats %0d, R beats %0d, errors %0d",
               table_q.size(), b_count, r_count, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
